// File: sim.f
source/gmii_rx_pkg.sv
source/gmii_rx_nibble_pair.sv
source/gmii_rx_preamble_strip.sv
source/gmii_rx_fcs_check.sv
source/gmii_rx_frame_counters.sv
source/gmii_rx_top.sv
tests/gmii_rx_feeder.sv
tests/gmii_rx_tb.sv

// File: source/gmii_rx_fcs_check.sv
// CRC-32 check and FCS removal
`timescale 1ns/100ps
`default_nettype none

module gmii_rx_fcs_check
    import gmii_rx_pkg::*;
(
    input  wire             gmii_rxclk_offset,
    input  wire             arst_n,
    input  wire gmii_byte_t pay_data,
    input  wire             pay_valid,
    input  wire             pay_sof,
    input  wire             pay_end,
    output gmii_byte_t      rx_data,
    output logic            rx_valid,
    output logic            rx_sof,
    output logic            frame_done,
    output logic            frame_good,
    output frame_len_t      frame_len
);

    // the register shifts right, so polynomial and residue are bit reversed
    localparam crc_t poly_rev    = {<<{crc_poly}};
    localparam crc_t residue_rev = {<<{crc_residue}};
    localparam crc_t crc_init    = '1;

    crc_t       crc_q;
    gmii_byte_t dly [4];
    logic [2:0] fill;
    frame_len_t len_q;
    logic       release_byte;

    function automatic crc_t crc_update(crc_t crc, gmii_byte_t data);
        crc_t c;
        c = crc ^ crc_t'(data);
        for (int i = 0; i < 8; i++)
        begin
            if (c[0])
                c = (c >> 1) ^ poly_rev;
            else
                c = c >> 1;
        end
        return c;
    endfunction

    // oldest byte leaves once four newer ones are held
    assign release_byte = pay_valid && !pay_sof && (fill == 3'd4);

    always_ff @(posedge gmii_rxclk_offset or negedge arst_n)
    begin
        if (!arst_n)
        begin
            fill       <= 3'd0;
            len_q      <= '0;
            rx_valid   <= 1'b0;
            rx_sof     <= 1'b0;
            frame_done <= 1'b0;
            frame_good <= 1'b0;
        end
        else
        begin
            rx_valid   <= release_byte;
            rx_sof     <= release_byte && (len_q == '0);
            frame_done <= pay_end;
            // fewer than four bytes cannot hold an FCS
            frame_good <= pay_end && (fill == 3'd4) && (crc_q == residue_rev);
            if (pay_end)
            begin
                fill  <= 3'd0;
                len_q <= '0;
            end
            else if (pay_valid)
            begin
                if (pay_sof)
                begin
                    fill  <= 3'd1;
                    len_q <= '0;
                end
                else
                begin
                    if (fill != 3'd4)
                        fill <= fill + 3'd1;
                    if (release_byte)
                        len_q <= len_q + 1'b1;
                end
            end
        end
    end

    always_ff @(posedge gmii_rxclk_offset)
    begin
        if (pay_valid)
        begin
            crc_q  <= crc_update(pay_sof ? crc_init : crc_q, pay_data);
            dly[0] <= pay_data;
            dly[1] <= dly[0];
            dly[2] <= dly[1];
            dly[3] <= dly[2];
        end
        if (release_byte)
            rx_data <= dly[3];
        if (pay_end)
            frame_len <= len_q;
    end

    // payload bytes only follow a start of frame
    a_sof_first: assert property (
        @(posedge gmii_rxclk_offset) disable iff (!arst_n)
        (pay_valid && !pay_sof) |-> (fill != 3'd0)
    );

endmodule

`default_nettype wire

// File: source/gmii_rx_frame_counters.sv
// Receive frame statistics
`timescale 1ns/100ps
`default_nettype none

module gmii_rx_frame_counters
    import gmii_rx_pkg::*;
(
    input  wire         gmii_rxclk_offset,
    input  wire         arst_n,
    input  wire         frame_done,
    input  wire         frame_good,
    input  wire         pay_drop,
    output stat_count_t good_count,
    output stat_count_t crc_err_count,
    output stat_count_t drop_count
);

    // counters hold at all ones
    function automatic stat_count_t sat_inc(stat_count_t value);
        if (value == '1)
            return value;
        else
            return value + 1'b1;
    endfunction

    always_ff @(posedge gmii_rxclk_offset or negedge arst_n)
    begin
        if (!arst_n)
        begin
            good_count    <= '0;
            crc_err_count <= '0;
            drop_count    <= '0;
        end
        else
        begin
            if (frame_done && frame_good)
                good_count <= sat_inc(good_count);
            if (frame_done && !frame_good)
                crc_err_count <= sat_inc(crc_err_count);
            if (pay_drop)
                drop_count <= sat_inc(drop_count);
        end
    end

    // delivered and dropped frames are separated by the interframe gap
    a_done_drop_apart: assert property (
        @(posedge gmii_rxclk_offset) disable iff (!arst_n)
        !(frame_done && pay_drop)
    );

endmodule

`default_nettype wire

// File: source/gmii_rx_nibble_pair.sv
// GMII/MII receive byte assembly
`timescale 1ns/100ps
`default_nettype none

module gmii_rx_nibble_pair
    import gmii_rx_pkg::*;
#(
    parameter bit giga_mode = 1'b1
)
(
    input  wire             gmii_rxclk_offset,
    input  wire             arst_n,
    input  wire             gmii_rxctrl,
    input  wire gmii_byte_t gmii_rxdata,
    output gmii_byte_t      byte_data,
    output logic            byte_valid,
    output logic            byte_active,
    output logic            pair_err
);

    // frame span, one clock behind the lines
    always_ff @(posedge gmii_rxclk_offset or negedge arst_n)
    begin
        if (!arst_n)
            byte_active <= 1'b0;
        else
            byte_active <= gmii_rxctrl;
    end

    generate
        if (giga_mode)
        begin : g_giga
            // a full byte on every clock
            always_ff @(posedge gmii_rxclk_offset or negedge arst_n)
            begin
                if (!arst_n)
                    byte_valid <= 1'b0;
                else
                    byte_valid <= gmii_rxctrl;
            end

            always_ff @(posedge gmii_rxclk_offset)
            begin
                if (gmii_rxctrl)
                    byte_data <= gmii_rxdata;
            end

            assign pair_err = 1'b0;
        end
        else
        begin : g_mii
            // high when the low nibble of a byte is held
            logic       phase;
            logic [3:0] low_nib;

            always_ff @(posedge gmii_rxclk_offset or negedge arst_n)
            begin
                if (!arst_n)
                begin
                    phase      <= 1'b0;
                    byte_valid <= 1'b0;
                    pair_err   <= 1'b0;
                end
                else
                begin
                    byte_valid <= gmii_rxctrl & phase;
                    // frame ended with half a byte pending
                    pair_err   <= byte_active & ~gmii_rxctrl & phase;
                    if (gmii_rxctrl)
                        phase <= ~phase;
                    else
                        phase <= 1'b0;
                end
            end

            // low nibble arrives first
            always_ff @(posedge gmii_rxclk_offset)
            begin
                if (gmii_rxctrl)
                begin
                    if (!phase)
                        low_nib <= gmii_rxdata[3:0];
                    else
                        byte_data <= {gmii_rxdata[3:0], low_nib};
                end
            end
        end
    endgenerate

    // a byte handed on never carries unknown bits
    a_valid_known: assert property (
        @(posedge gmii_rxclk_offset) disable iff (!arst_n)
        byte_valid |-> !$isunknown(byte_data)
    );

endmodule

`default_nettype wire

// File: source/gmii_rx_pkg.sv
// GMII receive shared definitions
`default_nettype none

package gmii_rx_pkg;

    // one byte on the receive lines, upper half unused in MII mode
    typedef logic [7:0] gmii_byte_t;

    // payload length in bytes, FCS excluded
    typedef logic [15:0] frame_len_t;

    // statistics counter value
    typedef logic [15:0] stat_count_t;

    // CRC-32 register
    typedef logic [31:0] crc_t;

    // preamble stripper states
    typedef enum logic [1:0]
    {
        st_idle,
        st_preamble,
        st_payload,
        st_drop
    } strip_state_t;

    // line constants
    localparam gmii_byte_t preamble_byte = 8'h55;
    localparam gmii_byte_t sfd_byte      = 8'hd5;

    // longest run of 55 bytes accepted ahead of the SFD
    localparam int max_preamble = 7;

    // register value once a correct FCS has been shifted in
    localparam crc_t crc_residue = 32'hc704dd7b;

    // CRC-32 generator, normal bit order
    localparam crc_t crc_poly = 32'h04c11db7;

endpackage

`default_nettype wire

// File: source/gmii_rx_preamble_strip.sv
// Preamble and SFD removal
`timescale 1ns/100ps
`default_nettype none

module gmii_rx_preamble_strip
    import gmii_rx_pkg::*;
(
    input  wire             gmii_rxclk_offset,
    input  wire             arst_n,
    input  wire gmii_byte_t byte_data,
    input  wire             byte_valid,
    input  wire             byte_active,
    input  wire             pair_err,
    output gmii_byte_t      pay_data,
    output logic            pay_valid,
    output logic            pay_sof,
    output logic            pay_end,
    output logic            pay_drop
);

    strip_state_t state;
    logic [3:0]   pre_cnt;
    logic         first_byte;
    logic         frame_end;

    // frame span closed while a frame is still open here
    assign frame_end = ~byte_active && (state != st_idle);

    always_ff @(posedge gmii_rxclk_offset or negedge arst_n)
    begin
        if (!arst_n)
        begin
            state      <= st_idle;
            pre_cnt    <= 4'd0;
            first_byte <= 1'b0;
            pay_valid  <= 1'b0;
            pay_sof    <= 1'b0;
            pay_end    <= 1'b0;
            pay_drop   <= 1'b0;
        end
        else
        begin
            pay_valid <= 1'b0;
            pay_sof   <= 1'b0;
            pay_end   <= 1'b0;
            pay_drop  <= 1'b0;
            if (frame_end)
            begin
                state <= st_idle;
                // a broken nibble count also discards the frame
                if (state == st_payload && !pair_err)
                    pay_end <= 1'b1;
                else
                    pay_drop <= 1'b1;
            end
            else if (byte_valid)
            begin
                case (state)
                    st_idle:
                    begin
                        if (byte_data == preamble_byte)
                        begin
                            state   <= st_preamble;
                            pre_cnt <= 4'd1;
                        end
                        else
                            state <= st_drop;
                    end
                    st_preamble:
                    begin
                        if (byte_data == sfd_byte)
                        begin
                            state      <= st_payload;
                            first_byte <= 1'b1;
                        end
                        else if (byte_data == preamble_byte &&
                                 pre_cnt != 4'(max_preamble))
                            pre_cnt <= pre_cnt + 4'd1;
                        else
                            state <= st_drop;
                    end
                    st_payload:
                    begin
                        pay_valid  <= 1'b1;
                        pay_sof    <= first_byte;
                        first_byte <= 1'b0;
                    end
                    default:
                    begin
                        // st_drop, wait for the frame to end
                    end
                endcase
            end
        end
    end

    always_ff @(posedge gmii_rxclk_offset)
    begin
        if (byte_valid && state == st_payload)
            pay_data <= byte_data;
    end

    a_pay_in_payload: assert property (
        @(posedge gmii_rxclk_offset) disable iff (!arst_n)
        (pay_valid || pay_sof) |-> (state == st_payload)
    );

endmodule

`default_nettype wire

// File: source/gmii_rx_top.sv
// GMII receive front end
`timescale 1ns/100ps
`default_nettype none

module gmii_rx_top
    import gmii_rx_pkg::*;
#(
    parameter bit giga_mode = 1'b1
)
(
    input  wire             gmii_rxclk_offset,
    input  wire             arst_n,
    input  wire             gmii_rxctrl,
    input  wire gmii_byte_t gmii_rxdata,
    output gmii_byte_t      rx_data,
    output logic            rx_valid,
    output logic            rx_sof,
    output logic            frame_done,
    output logic            frame_good,
    output frame_len_t      frame_len,
    output stat_count_t     good_count,
    output stat_count_t     crc_err_count,
    output stat_count_t     drop_count
);

    // byte stream
    gmii_byte_t byte_data;
    logic       byte_valid;
    logic       byte_active;
    logic       pair_err;

    // payload stream, preamble and SFD removed
    gmii_byte_t pay_data;
    logic       pay_valid;
    logic       pay_sof;
    logic       pay_end;
    logic       pay_drop;

    gmii_rx_nibble_pair #(
        .giga_mode (giga_mode)
    ) u_nibble_pair (
        .gmii_rxclk_offset (gmii_rxclk_offset),
        .arst_n            (arst_n),
        .gmii_rxctrl       (gmii_rxctrl),
        .gmii_rxdata       (gmii_rxdata),
        .byte_data         (byte_data),
        .byte_valid        (byte_valid),
        .byte_active       (byte_active),
        .pair_err          (pair_err)
    );

    gmii_rx_preamble_strip u_preamble_strip (
        .gmii_rxclk_offset (gmii_rxclk_offset),
        .arst_n            (arst_n),
        .byte_data         (byte_data),
        .byte_valid        (byte_valid),
        .byte_active       (byte_active),
        .pair_err          (pair_err),
        .pay_data          (pay_data),
        .pay_valid         (pay_valid),
        .pay_sof           (pay_sof),
        .pay_end           (pay_end),
        .pay_drop          (pay_drop)
    );

    gmii_rx_fcs_check u_fcs_check (
        .gmii_rxclk_offset (gmii_rxclk_offset),
        .arst_n            (arst_n),
        .pay_data          (pay_data),
        .pay_valid         (pay_valid),
        .pay_sof           (pay_sof),
        .pay_end           (pay_end),
        .rx_data           (rx_data),
        .rx_valid          (rx_valid),
        .rx_sof            (rx_sof),
        .frame_done        (frame_done),
        .frame_good        (frame_good),
        .frame_len         (frame_len)
    );

    gmii_rx_frame_counters u_frame_counters (
        .gmii_rxclk_offset (gmii_rxclk_offset),
        .arst_n            (arst_n),
        .frame_done        (frame_done),
        .frame_good        (frame_good),
        .pay_drop          (pay_drop),
        .good_count        (good_count),
        .crc_err_count     (crc_err_count),
        .drop_count        (drop_count)
    );

endmodule

`default_nettype wire

// File: tests/gmii_rx_feeder.sv
// GMII receive frame source
`timescale 1ns/100ps
`default_nettype none

module gmii_rx_feeder
    import gmii_rx_pkg::*;
#(
    parameter bit giga_mode  = 1'b1,
    parameter int num_frames = 200
)
(
    input  wire        gmii_rxclk_offset,
    input  wire        arst_n,
    output logic       gmii_rxctrl,
    output gmii_byte_t gmii_rxdata,
    output gmii_byte_t exp_data,
    output logic       exp_push,
    output logic       fault_fcs,
    output logic       fault_pre,
    output logic       fault_nib,
    output logic       rec_push,
    output frame_len_t rec_len,
    output logic       done
);

    logic [31:0] lfsr;
    gmii_byte_t  payload [64];
    int          frame_idx;

    // taps 32, 22, 2, 1
    function automatic logic [31:0] lfsr_next(logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    task automatic take_bits(input int n, output logic [31:0] v);
        int i;
        v = '0;
        for (i = 0; i < n; i++)
        begin
            lfsr = lfsr_next(lfsr);
            v = {v[30:0], lfsr[0]};
        end
    endtask

    // bit-serial CRC-32, data bits enter lsb first
    function automatic crc_t crc_serial(crc_t crc, gmii_byte_t b);
        crc_t poly_r;
        logic fb;
        int   i;
        for (i = 0; i < 32; i++)
            poly_r[i] = crc_poly[31 - i];
        for (i = 0; i < 8; i++)
        begin
            fb  = crc[0] ^ b[i];
            crc = crc >> 1;
            if (fb)
                crc = crc ^ poly_r;
        end
        return crc;
    endfunction

    // one clock on the receive lines
    task automatic drive(input logic ctrl, input gmii_byte_t d, input logic push,
                         input gmii_byte_t pd);
        @(posedge gmii_rxclk_offset);
        gmii_rxctrl <= ctrl;
        gmii_rxdata <= d;
        exp_push    <= push;
        exp_data    <= pd;
        rec_push    <= 1'b0;
    endtask

    task automatic send_byte(input gmii_byte_t b, input logic pay);
        if (giga_mode)
            drive(1'b1, b, pay, b);
        else
        begin
            drive(1'b1, {4'h0, b[3:0]}, 1'b0, b);
            drive(1'b1, {4'h0, b[7:4]}, pay, b);
        end
    endtask

    task automatic send_idle(input int n);
        repeat (giga_mode ? n : 2 * n)
            drive(1'b0, 8'h00, 1'b0, 8'h00);
    endtask

    // kind 0-7 clean, 8-9 FCS bit flip, 10 bad preamble byte, 11 no SFD,
    // 12 nine 55 bytes, 13-15 extra nibble in MII mode and clean otherwise
    task automatic send_frame();
        logic [31:0] r;
        int          plen;
        int          kind;
        int          gap;
        int          bad_pos;
        int          i;
        gmii_byte_t  bad_val;
        crc_t        crc;
        take_bits(6, r);
        plen = int'(r[5:0]) + 1;
        take_bits(4, r);
        kind = int'(r[3:0]);
        take_bits(4, r);
        gap = 12 + int'(r % 9);
        take_bits(3, r);
        bad_pos = int'(r % 7);
        take_bits(7, r);
        // lsb set, so never 55 and never d5
        bad_val = preamble_byte ^ {r[6:0], 1'b1};
        for (i = 0; i < plen; i++)
        begin
            take_bits(8, r);
            payload[i] = r[7:0];
        end
        // with the SFD left out the first payload byte must not stand in for it
        if (kind == 11 && payload[0] == sfd_byte)
            payload[0] = 8'h00;
        crc = '1;
        for (i = 0; i < plen; i++)
            crc = crc_serial(crc, payload[i]);
        crc = ~crc;
        if (kind == 8 || kind == 9)
        begin
            take_bits(5, r);
            crc[r[4:0]] = ~crc[r[4:0]];
        end
        send_idle(gap);
        fault_fcs <= (kind == 8 || kind == 9);
        fault_pre <= (kind >= 10 && kind <= 12);
        fault_nib <= (kind >= 13) && !giga_mode;
        for (i = 0; i < ((kind == 12) ? 9 : 7); i++)
            send_byte((kind == 10 && i == bad_pos) ? bad_val : preamble_byte, 1'b0);
        if (kind != 11)
            send_byte(sfd_byte, 1'b0);
        for (i = 0; i < plen; i++)
            send_byte(payload[i], 1'b1);
        for (i = 0; i < 4; i++)
            send_byte(crc[8 * i +: 8], 1'b0);
        if (kind >= 13 && !giga_mode)
            drive(1'b1, {4'h0, r[3:0]}, 1'b0, 8'h00);
        drive(1'b0, 8'h00, 1'b0, 8'h00);
        rec_push <= 1'b1;
        rec_len  <= frame_len_t'(plen);
    endtask

    initial
    begin
        gmii_rxctrl = 1'b0;
        gmii_rxdata = '0;
        exp_data    = '0;
        exp_push    = 1'b0;
        fault_fcs   = 1'b0;
        fault_pre   = 1'b0;
        fault_nib   = 1'b0;
        rec_push    = 1'b0;
        rec_len     = '0;
        done        = 1'b0;
        lfsr        = 32'h494e_cb54;
        wait (arst_n);
        for (frame_idx = 0; frame_idx < num_frames; frame_idx++)
            send_frame();
        // trailing gap lets the last verdict and counters settle
        send_idle(20);
        done <= 1'b1;
    end

endmodule

`default_nettype wire

// File: tests/gmii_rx_tb.sv
// GMII receive testbench
`timescale 1ns/100ps
`default_nettype none

module gmii_rx_tb
    import gmii_rx_pkg::*;
#(
    parameter bit giga_mode = 1'b1
);

    localparam int num_frames = 200;
    // 100 byte times per frame at most, two clocks per byte in MII mode
    localparam longint watchdog_ns =
        longint'(num_frames) * 100 * (giga_mode ? 1 : 2) * 20 + 20000;

    logic        gmii_rxclk_offset;
    logic        arst_n;
    logic        gmii_rxctrl;
    gmii_byte_t  gmii_rxdata;
    gmii_byte_t  rx_data;
    logic        rx_valid;
    logic        rx_sof;
    logic        frame_done;
    logic        frame_good;
    frame_len_t  frame_len;
    stat_count_t good_count;
    stat_count_t crc_err_count;
    stat_count_t drop_count;

    gmii_byte_t  exp_data;
    logic        exp_push;
    logic        fault_fcs;
    logic        fault_pre;
    logic        fault_nib;
    logic        rec_push;
    frame_len_t  rec_len;
    logic        feed_done;

    // reference model state
    gmii_byte_t  exp_bytes [$];
    bit          exp_sof [$];
    frame_len_t  exp_len [$];
    bit          exp_good [$];
    bit          first_pending = 1'b1;
    stat_count_t good_exp = '0;
    stat_count_t crc_exp = '0;
    stat_count_t drop_exp = '0;
    int          value_errors = 0;
    int          frame_errors = 0;

    gmii_rx_top #(
        .giga_mode (giga_mode)
    ) DUT (
        .gmii_rxclk_offset (gmii_rxclk_offset),
        .arst_n            (arst_n),
        .gmii_rxctrl       (gmii_rxctrl),
        .gmii_rxdata       (gmii_rxdata),
        .rx_data           (rx_data),
        .rx_valid          (rx_valid),
        .rx_sof            (rx_sof),
        .frame_done        (frame_done),
        .frame_good        (frame_good),
        .frame_len         (frame_len),
        .good_count        (good_count),
        .crc_err_count     (crc_err_count),
        .drop_count        (drop_count)
    );

    gmii_rx_feeder #(
        .giga_mode  (giga_mode),
        .num_frames (num_frames)
    ) feeder (
        .gmii_rxclk_offset (gmii_rxclk_offset),
        .arst_n            (arst_n),
        .gmii_rxctrl       (gmii_rxctrl),
        .gmii_rxdata       (gmii_rxdata),
        .exp_data          (exp_data),
        .exp_push          (exp_push),
        .fault_fcs         (fault_fcs),
        .fault_pre         (fault_pre),
        .fault_nib         (fault_nib),
        .rec_push          (rec_push),
        .rec_len           (rec_len),
        .done              (feed_done)
    );

    task automatic check_byte(input gmii_byte_t got, input gmii_byte_t exp, input string what);
        if (got !== exp)
        begin
            value_errors++;
            $display("Error at %0t ns: %s is %h, expected %h", $time, what, got, exp);
        end
    endtask

    task automatic check_len(input frame_len_t got, input frame_len_t exp, input string what);
        if (got !== exp)
        begin
            value_errors++;
            $display("Error at %0t ns: %s is %0d, expected %0d", $time, what, got, exp);
        end
    endtask

    task automatic check_count(input stat_count_t got, input stat_count_t exp,
                               input string what);
        if (got !== exp)
        begin
            value_errors++;
            $display("Error at %0t ns: %s is %0d, expected %0d", $time, what, got, exp);
        end
    endtask

    task automatic check_flag(input bit got, input bit exp, input string what);
        if (got !== exp)
        begin
            value_errors++;
            $display("Error at %0t ns: %s is %b, expected %b", $time, what, got, exp);
        end
    endtask

    initial
    begin
        gmii_rxclk_offset = 1'b0;
        forever
            #10 gmii_rxclk_offset = ~gmii_rxclk_offset;
    end

    // model side: a broken preamble hides the payload, an odd nibble count
    // still lets the payload out but suppresses the verdict
    always @(posedge gmii_rxclk_offset)
    begin
        if (arst_n)
        begin
            if (exp_push && !fault_pre)
            begin
                exp_bytes.push_back(exp_data);
                exp_sof.push_back(first_pending);
                first_pending = 1'b0;
            end
            if (rec_push)
            begin
                first_pending = 1'b1;
                if (fault_pre || fault_nib)
                    drop_exp++;
                else
                begin
                    exp_len.push_back(rec_len);
                    exp_good.push_back(!fault_fcs);
                    if (fault_fcs)
                        crc_exp++;
                    else
                        good_exp++;
                end
            end
            // DUT side
            if (rx_valid)
            begin
                if (exp_bytes.size() == 0)
                begin
                    frame_errors++;
                    $display("unexpected rx_valid byte %h at %0t ns", rx_data, $time);
                end
                else
                begin
                    check_byte(rx_data, exp_bytes.pop_front(), "rx_data");
                    check_flag(rx_sof, exp_sof.pop_front(), "rx_sof");
                end
            end
            else
                check_flag(rx_sof, 1'b0, "rx_sof without rx_valid");
            if (frame_done)
            begin
                if (exp_len.size() == 0)
                begin
                    frame_errors++;
                    $display("frame_done at %0t ns with no frame expected", $time);
                end
                else
                begin
                    check_flag(frame_good, exp_good.pop_front(), "frame_good");
                    check_len(frame_len, exp_len.pop_front(), "frame_len");
                end
                if (exp_bytes.size() != 0)
                begin
                    frame_errors++;
                    $display("frame ended at %0t ns with %0d payload bytes not delivered",
                             $time, exp_bytes.size());
                    exp_bytes.delete();
                    exp_sof.delete();
                end
            end
        end
    end

    initial
    begin
        arst_n = 1'b0;
        repeat (10)
            @(posedge gmii_rxclk_offset);
        arst_n <= 1'b1;
        @(posedge gmii_rxclk_offset);
        check_flag(rx_valid, 1'b0, "rx_valid after reset");
        check_flag(frame_done, 1'b0, "frame_done after reset");
        check_count(good_count, '0, "good_count after reset");
        check_count(drop_count, '0, "drop_count after reset");
        while (!feed_done)
            @(posedge gmii_rxclk_offset);
        check_count(good_count, good_exp, "good_count");
        check_count(crc_err_count, crc_exp, "crc_err_count");
        check_count(drop_count, drop_exp, "drop_count");
        if (exp_len.size() != 0)
        begin
            frame_errors++;
            $display("%0d frames were expected but never completed", exp_len.size());
        end
        if (exp_bytes.size() != 0)
        begin
            frame_errors++;
            $display("%0d payload bytes were expected but never delivered", exp_bytes.size());
        end
        $display("value errors: %0d, frame errors: %0d", value_errors, frame_errors);
        if (value_errors == 0 && frame_errors == 0)
            $display("Regression passed");
        else
            $display("Regression failed");
        $finish;
    end

    // watchdog
    initial
    begin
        #(watchdog_ns);
        $display("watchdog expired before the feeder finished all frames");
        $display("Regression failed");
        $finish;
    end

endmodule

`default_nettype wire
